// File: Makefile
SIM  := obj_dir/Vtb_pet_bus_bridge
SRCS := $(wildcard hw/*.sv tests/*.sv tests/*.svh)

.PHONY: all run clean

all: run

$(SIM): files.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -f files.f \
		--top-module tb_pet_bus_bridge -o Vtb_pet_bus_bridge

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: files.f
+incdir+tests
hw/pet_bus_pkg.sv
hw/spi_byte.sv
hw/spi_cmd_decoder.sv
hw/cmd_fifo.sv
hw/bus_sequencer.sv
hw/pet_bus_bridge.sv
tests/tb_pet_bus_bridge.sv

// File: hw/bus_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer #(
    parameter int STROBE_CYCLES = 2
) (
    input  logic                           clk16_i,
    input  logic                           arst_n_i,
    input  logic                           empty_i,
    input  logic [pet_bus_pkg::CMD_W-1:0]  cmd_i,
    input  logic [pet_bus_pkg::DATA_W-1:0] bus_data_i,
    output logic                           pop_o,
    output logic [pet_bus_pkg::ADDR_W-1:0] bus_addr_o,
    output logic [pet_bus_pkg::DATA_W-1:0] bus_data_o,
    output logic                           bus_data_oe,
    output logic                           ram_ce_no,
    output logic                           ram_oe_no,
    output logic                           ram_we_no,
    output logic [pet_bus_pkg::DATA_W-1:0] rd_data_o,
    output logic                           rd_valid_o,
    output logic                           ready_no
);
    import pet_bus_pkg::*;

    localparam int CNT_W = (STROBE_CYCLES > 1) ? $clog2(STROBE_CYCLES) : 1;

    seq_state_e       state_q;
    logic [CNT_W-1:0] strobe_cnt;
    logic             wr_q;
    logic             start;
    logic             last_strobe;
    logic             active;

    // New access may begin from idle or straight out of RELEASE
    assign start       = !empty_i && (state_q == IDLE || state_q == RELEASE);
    assign pop_o       = start;
    assign last_strobe = (strobe_cnt == CNT_W'(STROBE_CYCLES - 1));
    assign active      = (state_q != IDLE);

    always_ff @(posedge clk16_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            strobe_cnt <= '0;
            wr_q       <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= 1'b0;
            if (start) begin
                wr_q <= cmd_i[CMD_W-1];
            end
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= SETUP;
                    end
                end
                SETUP: begin
                    strobe_cnt <= '0;
                    state_q    <= STROBE;
                end
                STROBE: begin
                    if (last_strobe) begin
                        state_q    <= RELEASE;
                        rd_valid_o <= !wr_q;
                    end else begin
                        strobe_cnt <= strobe_cnt + 1'b1;
                    end
                end
                RELEASE: begin
                    state_q <= start ? SETUP : IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Address and write data held from SETUP through RELEASE
    always_ff @(posedge clk16_i) begin
        if (start) begin
            bus_addr_o <= cmd_i[CMD_W-2 -: ADDR_W];
            bus_data_o <= cmd_i[DATA_W-1:0];
        end
        if (state_q == STROBE && last_strobe && !wr_q) begin
            rd_data_o <= bus_data_i;
        end
    end

    // Chip enable brackets the OE/WE pulse so WE rises while CE is still low
    assign ram_ce_no   = !active;
    assign ram_oe_no   = !(state_q == STROBE && !wr_q);
    assign ram_we_no   = !(state_q == STROBE && wr_q);
    assign bus_data_oe = active && wr_q;

    // Ready only once nothing is queued or in flight
    assign ready_no = !(empty_i && state_q == IDLE);

endmodule

`default_nettype wire

// File: hw/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk16_i,
    input  logic                          arst_n_i,
    input  logic                          push_i,
    input  logic [pet_bus_pkg::CMD_W-1:0] push_data_i,
    input  logic                          pop_i,
    output logic [pet_bus_pkg::CMD_W-1:0] pop_data_o,
    output logic                          empty_o,
    output logic                          full_o
);
    import pet_bus_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CMD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap explicitly so any depth works, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(FIFO_DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Head entry is always on the output
    assign pop_data_o = mem[rd_ptr];

    always_ff @(posedge clk16_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk16_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/pet_bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module pet_bus_bridge #(
    parameter int FIFO_DEPTH    = 4,
    parameter int STROBE_CYCLES = 2
) (
    input  logic                           clk16_i,
    input  logic                           arst_n_i,

    // SPI1 from the MCU
    input  logic                           spi1_sck_i,
    input  logic                           spi1_cs_ni,
    input  logic                           spi1_mcu_tx_i,
    output logic                           spi1_mcu_rx_o,
    output logic                           spi1_mcu_rx_oe,
    output logic                           spi_ready_no,

    // System bus
    input  logic [pet_bus_pkg::DATA_W-1:0] bus_data_i,
    output logic [pet_bus_pkg::ADDR_W-1:0] bus_addr_o,
    output logic [pet_bus_pkg::DATA_W-1:0] bus_data_o,
    output logic                           bus_data_oe,

    // RAM strobes
    output logic                           ram_ce_no,
    output logic                           ram_oe_no,
    output logic                           ram_we_no
);
    import pet_bus_pkg::*;

    logic [DATA_W-1:0] rx_byte;
    logic              rx_valid;
    logic              frame_start;
    logic [DATA_W-1:0] tx_byte;
    logic              push;
    logic [CMD_W-1:0]  push_data;
    logic              full;
    logic              pop;
    logic              empty;
    logic [CMD_W-1:0]  pop_data;
    logic [DATA_W-1:0] rd_data;
    logic              rd_valid;

    // MISO driven only while selected
    assign spi1_mcu_rx_oe = !spi1_cs_ni;

    spi_byte u_spi_byte (
        .clk16_i      (clk16_i),
        .arst_n_i     (arst_n_i),
        .spi_cs_ni    (spi1_cs_ni),
        .spi_sck_i    (spi1_sck_i),
        .spi_rx_i     (spi1_mcu_tx_i),
        .tx_byte_i    (tx_byte),
        .spi_tx_o     (spi1_mcu_rx_o),
        .rx_byte_o    (rx_byte),
        .valid_o      (rx_valid),
        .frame_start_o(frame_start)
    );

    spi_cmd_decoder u_decoder (
        .clk16_i      (clk16_i),
        .arst_n_i     (arst_n_i),
        .rx_byte_i    (rx_byte),
        .rx_valid_i   (rx_valid),
        .frame_start_i(frame_start),
        .full_i       (full),
        .rd_data_i    (rd_data),
        .rd_valid_i   (rd_valid),
        .push_o       (push),
        .push_data_o  (push_data),
        .tx_byte_o    (tx_byte)
    );

    cmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk16_i    (clk16_i),
        .arst_n_i   (arst_n_i),
        .push_i     (push),
        .push_data_i(push_data),
        .pop_i      (pop),
        .pop_data_o (pop_data),
        .empty_o    (empty),
        .full_o     (full)
    );

    bus_sequencer #(
        .STROBE_CYCLES(STROBE_CYCLES)
    ) u_sequencer (
        .clk16_i    (clk16_i),
        .arst_n_i   (arst_n_i),
        .empty_i    (empty),
        .cmd_i      (pop_data),
        .bus_data_i (bus_data_i),
        .pop_o      (pop),
        .bus_addr_o (bus_addr_o),
        .bus_data_o (bus_data_o),
        .bus_data_oe(bus_data_oe),
        .ram_ce_no  (ram_ce_no),
        .ram_oe_no  (ram_oe_no),
        .ram_we_no  (ram_we_no),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid),
        .ready_no   (spi_ready_no)
    );

endmodule

`default_nettype wire

// File: hw/pet_bus_pkg.sv
`default_nettype none

package pet_bus_pkg;

    // System bus widths
    parameter int ADDR_W = 16;
    parameter int DATA_W = 8;

    // One queued command, packed as {write flag, address, data}
    parameter int CMD_W = ADDR_W + DATA_W + 1;

    // First byte of every SPI frame
    //   NOP   : opcode only
    //   READ  : opcode, address high, address low
    //   WRITE : opcode, address high, address low, data
    // Any other first byte is a one-byte frame and is ignored
    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_READ  = 8'h01,
        OP_WRITE = 8'h02
    } cmd_op_e;

    // Bus sequencer phases of one RAM access
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        STROBE,
        RELEASE
    } seq_state_e;

endpackage

`default_nettype wire

// File: hw/spi_byte.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte (
    input  logic                           clk16_i,
    input  logic                           arst_n_i,
    input  logic                           spi_cs_ni,
    input  logic                           spi_sck_i,
    input  logic                           spi_rx_i,
    input  logic [pet_bus_pkg::DATA_W-1:0] tx_byte_i,
    output logic                           spi_tx_o,
    output logic [pet_bus_pkg::DATA_W-1:0] rx_byte_o,
    output logic                           valid_o,
    output logic                           frame_start_o
);
    import pet_bus_pkg::*;

    localparam int BIT_W = $clog2(DATA_W);

    // Two flop synchronisers, plus one more flop of history for edges
    logic [1:0]        sck_sync;
    logic [1:0]        cs_sync;
    logic [1:0]        mosi_sync;
    logic              sck_prev;
    logic              cs_prev;

    logic              selected;
    logic              sck_rise;
    logic              sck_fall;
    logic              cs_fall;
    logic              byte_done;

    logic [BIT_W-1:0]  bit_cnt;
    logic [DATA_W-2:0] rx_shift;
    logic [DATA_W-1:0] tx_shift;

    always_ff @(posedge clk16_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sck_sync  <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
            sck_prev  <= 1'b0;
            cs_prev   <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck_i};
            cs_sync   <= {cs_sync[0], spi_cs_ni};
            mosi_sync <= {mosi_sync[0], spi_rx_i};
            sck_prev  <= sck_sync[1];
            cs_prev   <= cs_sync[1];
        end
    end

    assign selected  = !cs_sync[1];
    assign sck_rise  = selected && sck_sync[1] && !sck_prev;
    assign sck_fall  = selected && !sck_sync[1] && sck_prev;
    assign cs_fall   = cs_prev && !cs_sync[1];
    assign byte_done = sck_rise && (bit_cnt == BIT_W'(DATA_W - 1));

    always_ff @(posedge clk16_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bit_cnt       <= '0;
            valid_o       <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            valid_o       <= byte_done;
            frame_start_o <= cs_fall;
            if (!selected) begin
                // CS high throws away a partial byte
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Mode 0: sample MOSI on rising SCK, advance MISO on falling SCK
    always_ff @(posedge clk16_i) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[DATA_W-3:0], mosi_sync[1]};
        end
        if (byte_done) begin
            rx_byte_o <= {rx_shift, mosi_sync[1]};
        end
        if (cs_fall || byte_done) begin
            tx_shift <= tx_byte_i;
        end else if (sck_fall && bit_cnt != '0) begin
            // The falling edge that closes a byte would eat the fresh MSB
            tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
        end
    end

    assign spi_tx_o = tx_shift[DATA_W-1];

endmodule

`default_nettype wire

// File: hw/spi_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_decoder (
    input  logic                           clk16_i,
    input  logic                           arst_n_i,
    input  logic [pet_bus_pkg::DATA_W-1:0] rx_byte_i,
    input  logic                           rx_valid_i,
    input  logic                           frame_start_i,
    input  logic                           full_i,
    input  logic [pet_bus_pkg::DATA_W-1:0] rd_data_i,
    input  logic                           rd_valid_i,
    output logic                           push_o,
    output logic [pet_bus_pkg::CMD_W-1:0]  push_data_o,
    output logic [pet_bus_pkg::DATA_W-1:0] tx_byte_o
);
    import pet_bus_pkg::*;

    // Index of the next byte expected in the current frame
    logic [1:0]        byte_idx;
    cmd_op_e           op_q;
    logic [DATA_W-1:0] addr_hi_q;
    logic [DATA_W-1:0] addr_lo_q;

    logic              frame_done;
    logic [CMD_W-1:0]  cmd_d;

    // A read ends on the low address byte, a write on its data byte
    always_comb begin
        frame_done = 1'b0;
        cmd_d      = '0;
        if (rx_valid_i) begin
            if (byte_idx == 2'd2 && op_q == OP_READ) begin
                frame_done = 1'b1;
                cmd_d      = {1'b0, addr_hi_q, rx_byte_i, {DATA_W{1'b0}}};
            end else if (byte_idx == 2'd3) begin
                frame_done = 1'b1;
                cmd_d      = {1'b1, addr_hi_q, addr_lo_q, rx_byte_i};
            end
        end
    end

    always_ff @(posedge clk16_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            byte_idx  <= 2'd0;
            op_q      <= OP_NOP;
            push_o    <= 1'b0;
            tx_byte_o <= '0;
        end else begin
            // Full FIFO drops the whole frame
            push_o <= frame_done && !full_i;

            if (rd_valid_i) begin
                tx_byte_o <= rd_data_i;
            end

            if (frame_start_i) begin
                // New CS low restarts, discarding anything cut short
                byte_idx <= 2'd0;
            end else if (rx_valid_i) begin
                case (byte_idx)
                    2'd0: begin
                        op_q <= cmd_op_e'(rx_byte_i);
                        case (cmd_op_e'(rx_byte_i))
                            OP_READ, OP_WRITE: byte_idx <= 2'd1;
                            default:           byte_idx <= 2'd0;
                        endcase
                    end
                    2'd1: begin
                        byte_idx <= 2'd2;
                    end
                    2'd2: begin
                        byte_idx <= (op_q == OP_READ) ? 2'd0 : 2'd3;
                    end
                    default: begin
                        byte_idx <= 2'd0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk16_i) begin
        if (rx_valid_i && byte_idx == 2'd1) begin
            addr_hi_q <= rx_byte_i;
        end
        if (rx_valid_i && byte_idx == 2'd2) begin
            addr_lo_q <= rx_byte_i;
        end
        if (frame_done) begin
            push_data_o <= cmd_d;
        end
    end

endmodule

`default_nettype wire

// File: tests/spi_master_tasks.svh
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAIL %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        errors++;
    end
endtask

// One mode 0 byte, MSB first, 8 clk16 periods per bit
task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
        spi1_mcu_tx_i = tx[i];
        repeat (4) @(negedge clk16_i);
        spi1_sck_i = 1'b1;
        rx[i] = spi1_mcu_rx_o;
        repeat (4) @(negedge clk16_i);
        spi1_sck_i = 1'b0;
    end
endtask

// Bytes leave from the top of frame; fewer than the opcode needs cuts it short
task automatic send_frame(input logic [31:0] frame, input int nbytes,
                          output logic [7:0] first_rx);
    logic [7:0] rx;
    spi1_cs_ni = 1'b0;
    repeat (8) @(negedge clk16_i);
    // MISO enable follows CS
    compare_value("spi1_mcu_rx_oe", 32'(spi1_mcu_rx_oe), 32'd1);
    for (int i = 0; i < nbytes; i++) begin
        spi_xfer(frame[31 - 8*i -: 8], rx);
        if (i == 0) begin
            first_rx = rx;
        end
    end
    repeat (4) @(negedge clk16_i);
    spi1_cs_ni = 1'b1;
    repeat (8) @(negedge clk16_i);
    compare_value("spi1_mcu_rx_oe", 32'(spi1_mcu_rx_oe), 32'd0);
endtask

task automatic wait_ready(input string what);
    int n;
    n = 0;
    while (spi_ready_no !== 1'b0 && n < READY_TIMEOUT) begin
        @(negedge clk16_i);
        n++;
    end
    if (spi_ready_no !== 1'b0) begin
        $display("ERROR at %0t ns: bridge never became ready after %s", $time, what);
        errors++;
    end
endtask

task automatic write_cmd(input logic [15:0] addr, input logic [7:0] data);
    logic [7:0] rx;
    send_frame({OP_WRITE, addr, data}, 4, rx);
    ref_mem[addr] = data;
endtask

// Read result comes back as the first MISO byte of the following frame
task automatic read_and_check(input logic [15:0] addr);
    logic [7:0] rx;
    send_frame({OP_READ, addr, 8'h00}, 3, rx);
    wait_ready("read frame");
    send_frame({OP_NOP, 24'h000000}, 1, rx);
    compare_value("spi1_mcu_rx_o", 32'(rx), 32'(ref_mem[addr]));
endtask

`endif

// File: tests/tb_pet_bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pet_bus_bridge;
    import pet_bus_pkg::*;

    localparam int FIFO_DEPTH    = 4;
    localparam int STROBE_CYCLES = 2;
    localparam int READY_TIMEOUT = 2000;
    localparam int NUM_WRITES    = 32;

    logic              clk16_i;
    logic              arst_n_i;
    logic              spi1_sck_i;
    logic              spi1_cs_ni;
    logic              spi1_mcu_tx_i;
    logic              spi1_mcu_rx_o;
    logic              spi1_mcu_rx_oe;
    logic              spi_ready_no;
    logic [DATA_W-1:0] bus_data_i;
    logic [ADDR_W-1:0] bus_addr_o;
    logic [DATA_W-1:0] bus_data_o;
    logic              bus_data_oe;
    logic              ram_ce_no;
    logic              ram_oe_no;
    logic              ram_we_no;

    // External RAM and its reference copy
    logic [7:0] ram     [0:65535];
    logic [7:0] ref_mem [0:65535];

    int errors;
    int err_mark;
    int tests_run;
    int tests_failed;
    int ce_low_cycles;
    int strobe_faults;

    `include "spi_master_tasks.svh"

    pet_bus_bridge #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .STROBE_CYCLES(STROBE_CYCLES)
    ) DUT (
        .clk16_i       (clk16_i),
        .arst_n_i      (arst_n_i),
        .spi1_sck_i    (spi1_sck_i),
        .spi1_cs_ni    (spi1_cs_ni),
        .spi1_mcu_tx_i (spi1_mcu_tx_i),
        .spi1_mcu_rx_o (spi1_mcu_rx_o),
        .spi1_mcu_rx_oe(spi1_mcu_rx_oe),
        .spi_ready_no  (spi_ready_no),
        .bus_data_i    (bus_data_i),
        .bus_addr_o    (bus_addr_o),
        .bus_data_o    (bus_data_o),
        .bus_data_oe   (bus_data_oe),
        .ram_ce_no     (ram_ce_no),
        .ram_oe_no     (ram_oe_no),
        .ram_we_no     (ram_we_no)
    );

    initial clk16_i = 1'b0;
    always #10 clk16_i = ~clk16_i;

    // Write lands as WE rises with the chip still enabled
    always @(posedge ram_we_no) begin
        if (ram_ce_no == 1'b0) begin
            ram[bus_addr_o] = bus_data_o;
        end
    end

    assign bus_data_i = (ram_oe_no == 1'b0) ? ram[bus_addr_o] : 8'h00;

    // Bus activity and strobe overlap watch
    always @(negedge clk16_i) begin
        if (arst_n_i) begin
            if (!ram_ce_no) begin
                ce_low_cycles++;
            end
            if (!ram_oe_no && !ram_we_no) begin
                $display("ERROR at %0t ns: OE and WE strobes low together", $time);
                strobe_faults++;
            end
            if (!ram_oe_no && bus_data_oe) begin
                $display("ERROR at %0t ns: data bus driven during a read", $time);
                strobe_faults++;
            end
            if (!ram_we_no && !bus_data_oe) begin
                $display("ERROR at %0t ns: data bus not driven during a write", $time);
                strobe_faults++;
            end
        end
    end

    task automatic begin_test();
        err_mark = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
    endtask

    initial begin
        logic [15:0] addr_q [$];
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  op;
        logic [7:0]  rx;
        int          ce_before;

        arst_n_i      = 1'b0;
        spi1_sck_i    = 1'b0;
        spi1_cs_ni    = 1'b1;
        spi1_mcu_tx_i = 1'b0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        ce_low_cycles = 0;
        strobe_faults = 0;
        void'($urandom(60674));

        for (int a = 0; a < 65536; a++) begin
            ram[16'(a)]     = 8'(a) ^ 8'(a >> 8) ^ 8'hA5;
            ref_mem[16'(a)] = ram[16'(a)];
        end

        repeat (4) @(negedge clk16_i);
        arst_n_i = 1'b1;
        repeat (2) @(negedge clk16_i);

        begin_test();
        compare_value("spi_ready_no", 32'(spi_ready_no), 32'd0);
        compare_value("ram_ce_no", 32'(ram_ce_no), 32'd1);
        compare_value("ram_oe_no", 32'(ram_oe_no), 32'd1);
        compare_value("ram_we_no", 32'(ram_we_no), 32'd1);
        compare_value("bus_data_oe", 32'(bus_data_oe), 32'd0);
        send_frame({OP_NOP, 24'h000000}, 1, rx);
        compare_value("spi1_mcu_rx_o", 32'(rx), 32'h00);
        end_test("reset state");

        begin_test();
        for (int i = 0; i < NUM_WRITES; i++) begin
            addr = 16'($urandom);
            data = 8'($urandom);
            addr_q.push_back(addr);
            write_cmd(addr, data);
            wait_ready("write frame");
        end
        foreach (addr_q[i]) begin
            read_and_check(addr_q[i]);
        end
        end_test("write then read");

        begin_test();
        addr_q.delete();
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            addr = 16'($urandom);
            addr_q.push_back(addr);
            write_cmd(addr, 8'($urandom));
        end
        wait_ready("write burst");
        foreach (addr_q[i]) begin
            read_and_check(addr_q[i]);
        end
        end_test("write burst");

        // Opcode and high address only, then CS rises
        begin_test();
        addr = 16'($urandom);
        data = ~ref_mem[addr];
        send_frame({OP_WRITE, addr, data}, 2, rx);
        wait_ready("aborted frame");
        read_and_check(addr);
        write_cmd(addr, data);
        wait_ready("write after abort");
        read_and_check(addr);
        end_test("aborted frame");

        begin_test();
        op = 8'h03 + 8'($urandom % 253);
        ce_before = ce_low_cycles;
        send_frame({op, 24'h000000}, 1, rx);
        wait_ready("unknown opcode");
        compare_value("ce_low_cycles", 32'(ce_low_cycles), 32'(ce_before));
        compare_value("ram_ce_no", 32'(ram_ce_no), 32'd1);
        end_test("unknown opcode");

        begin_test();
        compare_value("strobe_faults", 32'(strobe_faults), 32'd0);
        end_test("strobe exclusivity");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
